// ==== alu.sv ====
// Combinational RV32I ALU; shifts use b[4:0], LUI passes b through, unknown ops give zero
module alu (
    input  logic [exe_pkg::XLEN-1:0] a_i,
    input  logic [exe_pkg::XLEN-1:0] b_i,
    input  logic [exe_pkg::OP_W-1:0] op_i,
    output logic [exe_pkg::XLEN-1:0] result_o
);
    import exe_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = b_i[SHAMT_W-1:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            OP_ADD:  result_o = a_i + b_i;
            OP_SUB:  result_o = a_i - b_i;
            OP_SLL:  result_o = a_i << shamt;
            OP_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            OP_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            OP_XOR:  result_o = a_i ^ b_i;
            OP_SRL:  result_o = a_i >> shamt;
            OP_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            OP_OR:   result_o = a_i | b_i;
            OP_AND:  result_o = a_i & b_i;
            OP_LUI:  result_o = b_i;  // Immediate already shifted upstream
            default: result_o = '0;
        endcase
    end

endmodule

// ==== branch_unit.sv ====
// Branch and jump resolution; target is not checked for alignment here, the stage does that
module branch_unit (
    input  logic [exe_pkg::OP_W-1:0] op_i,
    input  logic [exe_pkg::XLEN-1:0] pc_i,
    input  logic [exe_pkg::XLEN-1:0] rs1_i,
    input  logic [exe_pkg::XLEN-1:0] rs2_i,
    input  logic [exe_pkg::XLEN-1:0] imm_i,
    output logic                     taken_o,
    output logic [exe_pkg::XLEN-1:0] target_o,
    output logic [exe_pkg::XLEN-1:0] link_o
);
    import exe_pkg::*;

    logic [XLEN-1:0] jalr_sum;
    logic            eq;
    logic            lt_s;
    logic            lt_u;

    assign eq       = rs1_i == rs2_i;
    assign lt_s     = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u     = rs1_i < rs2_i;
    assign jalr_sum = rs1_i + imm_i;

    always_comb begin
        case (op_i)
            OP_BEQ:           taken_o = eq;
            OP_BNE:           taken_o = ~eq;
            OP_BLT:           taken_o = lt_s;
            OP_BGE:           taken_o = ~lt_s;
            OP_BLTU:          taken_o = lt_u;
            OP_BGEU:          taken_o = ~lt_u;
            OP_JAL, OP_JALR:  taken_o = 1'b1;  // Jumps always redirect
            default:          taken_o = 1'b0;
        endcase
    end

    // JALR clears bit 0 of the sum
    assign target_o = (op_i == OP_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;
    assign link_o   = pc_i + XLEN'(4);

endmodule

// ==== div_unit.sv ====
// Radix-2 restoring divider, WIDTH+1 stall cycles; a request held after the result cycle restarts
module div_unit #(
    parameter int WIDTH = 32
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             kill_i,
    input  logic             request_i,
    input  logic             signed_i,
    input  logic [WIDTH-1:0] dvnd_i,
    input  logic [WIDTH-1:0] dvsr_i,
    output logic [WIDTH-1:0] quo_o,
    output logic [WIDTH-1:0] rmd_o,
    output logic             stall_o
);
    localparam int CNT_W = $clog2(WIDTH);

    logic             busy_q;
    logic             done_q;
    logic [CNT_W-1:0] cnt_q;
    logic [WIDTH-1:0] quo_q;       // Dividend shifts out as quotient bits shift in
    logic [WIDTH-1:0] rem_q;
    logic [WIDTH-1:0] dvsr_q;
    logic             neg_quo_q;
    logic             neg_rmd_q;
    logic             dvnd_neg;
    logic             dvsr_neg;
    logic [WIDTH:0]   rem_sh;
    logic             fits;

    assign dvnd_neg = signed_i & dvnd_i[WIDTH-1];
    assign dvsr_neg = signed_i & dvsr_i[WIDTH-1];
    assign rem_sh   = {rem_q, quo_q[WIDTH-1]};
    assign fits     = rem_sh >= {1'b0, dvsr_q};

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(WIDTH-1)) begin  // Last quotient bit
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end else if (done_q) begin
            done_q <= 1'b0;
        end else if (request_i) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!busy_q && !done_q && request_i) begin
            quo_q     <= dvnd_neg ? -dvnd_i : dvnd_i;
            dvsr_q    <= dvsr_neg ? -dvsr_i : dvsr_i;
            rem_q     <= '0;
            // Zero divisor keeps the quotient at all ones
            neg_quo_q <= (dvnd_neg ^ dvsr_neg) & (|dvsr_i);
            neg_rmd_q <= dvnd_neg;  // Remainder takes the dividend sign
        end else if (busy_q) begin
            rem_q <= fits ? rem_sh[WIDTH-1:0] - dvsr_q : rem_sh[WIDTH-1:0];
            quo_q <= {quo_q[WIDTH-2:0], fits};
        end
    end

    // Divide by zero ends with all-ones quotient and |dividend| as remainder.
    // Most negative / -1 gives 2^(WIDTH-1) unnegated, which is the same pattern.
    assign quo_o   = neg_quo_q ? -quo_q : quo_q;
    assign rmd_o   = neg_rmd_q ? -rem_q : rem_q;
    assign stall_o = busy_q | (request_i & ~done_q);

endmodule

// ==== exe_pkg.sv ====
// Shared RV32IM execute-stage constants; no 64-bit or W-suffix ops, interrupt causes fit in 4 bits
package exe_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN    = 32;
    localparam int REG_W   = 5;  // Physical register index
    localparam int UNIT_W  = 3;
    localparam int OP_W    = 5;
    localparam int CAUSE_W = 4;

    // Functional unit selector
    localparam logic [UNIT_W-1:0] UNIT_ALU    = 3'd0;
    localparam logic [UNIT_W-1:0] UNIT_MUL    = 3'd1;
    localparam logic [UNIT_W-1:0] UNIT_DIV    = 3'd2;
    localparam logic [UNIT_W-1:0] UNIT_BRANCH = 3'd3;
    localparam logic [UNIT_W-1:0] UNIT_SYSTEM = 3'd4;

    // ----------------------------------------
    // Operation codes
    // ----------------------------------------
    localparam logic [OP_W-1:0] OP_ADD    = 5'd0;  // Also AUIPC with PC operand
    localparam logic [OP_W-1:0] OP_SUB    = 5'd1;
    localparam logic [OP_W-1:0] OP_SLL    = 5'd2;
    localparam logic [OP_W-1:0] OP_SLT    = 5'd3;
    localparam logic [OP_W-1:0] OP_SLTU   = 5'd4;
    localparam logic [OP_W-1:0] OP_XOR    = 5'd5;
    localparam logic [OP_W-1:0] OP_SRL    = 5'd6;
    localparam logic [OP_W-1:0] OP_SRA    = 5'd7;
    localparam logic [OP_W-1:0] OP_OR     = 5'd8;
    localparam logic [OP_W-1:0] OP_AND    = 5'd9;
    localparam logic [OP_W-1:0] OP_LUI    = 5'd10;

    localparam logic [OP_W-1:0] OP_MUL    = 5'd11;
    localparam logic [OP_W-1:0] OP_MULH   = 5'd12;
    localparam logic [OP_W-1:0] OP_MULHSU = 5'd13;
    localparam logic [OP_W-1:0] OP_MULHU  = 5'd14;

    localparam logic [OP_W-1:0] OP_DIV    = 5'd15;
    localparam logic [OP_W-1:0] OP_DIVU   = 5'd16;
    localparam logic [OP_W-1:0] OP_REM    = 5'd17;
    localparam logic [OP_W-1:0] OP_REMU   = 5'd18;

    localparam logic [OP_W-1:0] OP_BEQ    = 5'd19;
    localparam logic [OP_W-1:0] OP_BNE    = 5'd20;
    localparam logic [OP_W-1:0] OP_BLT    = 5'd21;
    localparam logic [OP_W-1:0] OP_BGE    = 5'd22;
    localparam logic [OP_W-1:0] OP_BLTU   = 5'd23;
    localparam logic [OP_W-1:0] OP_BGEU   = 5'd24;
    localparam logic [OP_W-1:0] OP_JAL    = 5'd25;
    localparam logic [OP_W-1:0] OP_JALR   = 5'd26;

    // Exception causes, interrupt codes pass through unchanged
    localparam logic [CAUSE_W-1:0] CAUSE_INSTR_MISALIGNED = 4'd0;

endpackage

// ==== exe_stage.f ====
exe_pkg.sv
alu.sv
branch_unit.sv
mul_unit.sv
div_unit.sv
exe_stage.sv
exe_stage_asserts.sv
tb_exe_stage.sv

// ==== exe_stage.sv ====
// RV32IM execute stage without memory unit; inputs held while stall_o is high, new instr after kill
module exe_stage (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        kill_i,

    // Issued instruction from register read
    input  logic                        valid_i,
    input  logic [exe_pkg::UNIT_W-1:0]  unit_i,
    input  logic [exe_pkg::OP_W-1:0]    op_i,
    input  logic [exe_pkg::XLEN-1:0]    pc_i,
    input  logic [exe_pkg::XLEN-1:0]    imm_i,
    input  logic                        use_pc_i,
    input  logic                        use_imm_i,
    input  logic [exe_pkg::REG_W-1:0]   rs1_i,
    input  logic [exe_pkg::REG_W-1:0]   rs2_i,
    input  logic [exe_pkg::XLEN-1:0]    rs1_data_i,
    input  logic [exe_pkg::XLEN-1:0]    rs2_data_i,
    input  logic [exe_pkg::REG_W-1:0]   rd_i,
    input  logic                        bpred_taken_i,
    input  logic [exe_pkg::XLEN-1:0]    bpred_target_i,

    // Write-back forwarding
    input  logic                        wb_valid_i,
    input  logic [exe_pkg::REG_W-1:0]   wb_rd_i,
    input  logic [exe_pkg::XLEN-1:0]    wb_data_i,

    input  logic                        csr_interrupt_i,
    input  logic [exe_pkg::CAUSE_W-1:0] csr_interrupt_cause_i,

    output logic                        valid_o,
    output logic [exe_pkg::REG_W-1:0]   rd_o,
    output logic [exe_pkg::XLEN-1:0]    result_o,
    output logic                        stall_o,

    output logic                        ex_valid_o,
    output logic [exe_pkg::CAUSE_W-1:0] ex_cause_o,
    output logic [exe_pkg::XLEN-1:0]    ex_origin_o,

    output logic                        branch_taken_o,
    output logic [exe_pkg::XLEN-1:0]    branch_target_o,
    output logic                        correct_pred_o,

    output logic                        pmu_is_branch_o,
    output logic                        pmu_branch_taken_o,
    output logic                        pmu_miss_prediction_o,
    output logic                        pmu_stall_mul_o,
    output logic                        pmu_stall_div_o
);
    import exe_pkg::*;

    logic [XLEN-1:0] rs1_byp, rs2_byp;
    logic [XLEN-1:0] op_a, op_b;
    logic [XLEN-1:0] alu_res, mul_res, div_quo, div_rmd;
    logic [XLEN-1:0] br_target, br_link;
    logic            br_taken;
    logic            mul_stall, div_stall;
    logic            is_mul, is_div, is_branch;
    logic            div_signed;

    // ----------------------------------------
    // Bypass and operand select
    // ----------------------------------------
    assign rs1_byp = (wb_valid_i && rs1_i != '0 && rs1_i == wb_rd_i) ? wb_data_i : rs1_data_i;
    assign rs2_byp = (wb_valid_i && rs2_i != '0 && rs2_i == wb_rd_i) ? wb_data_i : rs2_data_i;
    assign op_a    = use_pc_i  ? pc_i  : rs1_byp;
    assign op_b    = use_imm_i ? imm_i : rs2_byp;

    assign is_mul     = valid_i && unit_i == UNIT_MUL;
    assign is_div     = valid_i && unit_i == UNIT_DIV;
    assign is_branch  = valid_i && unit_i == UNIT_BRANCH;
    assign div_signed = (op_i == OP_DIV) || (op_i == OP_REM);

    alu u_alu (.a_i(op_a), .b_i(op_b), .op_i(op_i), .result_o(alu_res));

    branch_unit u_branch (
        .op_i(op_i), .pc_i(pc_i), .rs1_i(rs1_byp), .rs2_i(rs2_byp), .imm_i(imm_i),
        .taken_o(br_taken), .target_o(br_target), .link_o(br_link)
    );

    mul_unit #(.WIDTH(XLEN)) u_mul (
        .clk_i(clk_i), .rst_i(rst_i), .kill_i(kill_i), .request_i(is_mul), .op_i(op_i),
        .src1_i(rs1_byp), .src2_i(rs2_byp), .result_o(mul_res), .stall_o(mul_stall)
    );

    div_unit #(.WIDTH(XLEN)) u_div (
        .clk_i(clk_i), .rst_i(rst_i), .kill_i(kill_i), .request_i(is_div),
        .signed_i(div_signed), .dvnd_i(rs1_byp), .dvsr_i(op_b),
        .quo_o(div_quo), .rmd_o(div_rmd), .stall_o(div_stall)
    );

    // ----------------------------------------
    // Result and exceptions
    // ----------------------------------------
    always_comb begin
        case (unit_i)
            UNIT_ALU:    result_o = alu_res;
            UNIT_MUL:    result_o = mul_res;
            UNIT_DIV:    result_o = (op_i == OP_REM || op_i == OP_REMU) ? div_rmd : div_quo;
            UNIT_BRANCH: result_o = br_link;
            UNIT_SYSTEM: result_o = rs1_byp;  // CSR write data
            default:     result_o = '0;
        endcase
    end

    always_comb begin
        ex_valid_o  = 1'b0;
        ex_cause_o  = CAUSE_INSTR_MISALIGNED;
        ex_origin_o = '0;
        if (valid_i && csr_interrupt_i) begin  // Interrupt wins
            ex_valid_o = 1'b1;
            ex_cause_o = csr_interrupt_cause_i;
        end else if (is_branch && br_taken && br_target[1:0] != 2'b00) begin
            ex_valid_o  = 1'b1;
            ex_origin_o = br_target;
        end
    end

    assign valid_o = valid_i;
    assign rd_o    = rd_i;
    assign stall_o = (is_mul & mul_stall) | (is_div & div_stall);

    assign branch_taken_o  = is_branch & br_taken;
    assign branch_target_o = br_target;
    // Target only matters when the branch is taken
    assign correct_pred_o  = !is_branch || (br_taken == bpred_taken_i &&
                             (!br_taken || br_target == bpred_target_i));

    assign pmu_is_branch_o       = is_branch;
    assign pmu_branch_taken_o    = is_branch & br_taken;
    assign pmu_miss_prediction_o = ~correct_pred_o;
    assign pmu_stall_mul_o       = is_mul & mul_stall;
    assign pmu_stall_div_o       = is_div & div_stall;

endmodule

// ==== exe_stage_asserts.sv ====
// Bound into exe_stage; reads bypass nets and the divider busy flag, needs valid_i low in reset
module exe_stage_asserts (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      kill_i,
    input logic                      valid_i,
    input logic                      stall_i,
    input logic                      div_busy_i,
    input logic [exe_pkg::REG_W-1:0] rs1_i,
    input logic [exe_pkg::REG_W-1:0] rs2_i,
    input logic [exe_pkg::XLEN-1:0]  rs1_data_i,
    input logic [exe_pkg::XLEN-1:0]  rs2_data_i,
    input logic [exe_pkg::XLEN-1:0]  rs1_byp_i,
    input logic [exe_pkg::XLEN-1:0]  rs2_byp_i
);

    assert property (@(posedge clk_i) rst_i |=> !stall_i && !div_busy_i)
        else $error("stall_o or divider busy in the cycle after reset");

    assert property (@(posedge clk_i) stall_i |-> valid_i)
        else $error("stall_o high without a valid instruction");

    // Divider drops its operation one cycle after a kill
    assert property (@(posedge clk_i) disable iff (rst_i) kill_i |=> !stall_i && !div_busy_i)
        else $error("stall_o or divider busy still high after kill_i");

    // Register x0 is never forwarded
    assert property (@(posedge clk_i) rs1_i == '0 |-> rs1_byp_i == rs1_data_i)
        else $error("rs1 bypass taken from index 0");
    assert property (@(posedge clk_i) rs2_i == '0 |-> rs2_byp_i == rs2_data_i)
        else $error("rs2 bypass taken from index 0");

endmodule

bind exe_stage exe_stage_asserts u_asserts (
    .clk_i(clk_i), .rst_i(rst_i), .kill_i(kill_i), .valid_i(valid_i), .stall_i(stall_o),
    .div_busy_i(u_div.busy_q),
    .rs1_i(rs1_i), .rs2_i(rs2_i), .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
    .rs1_byp_i(rs1_byp), .rs2_byp_i(rs2_byp)
);

// ==== mul_unit.sv ====
// Two-stage multiplier, stalls two cycles per request; upstream must hold op and sources meanwhile
module mul_unit #(
    parameter int WIDTH = 32
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     kill_i,
    input  logic                     request_i,
    input  logic [exe_pkg::OP_W-1:0] op_i,
    input  logic [WIDTH-1:0]         src1_i,
    input  logic [WIDTH-1:0]         src2_i,
    output logic [WIDTH-1:0]         result_o,
    output logic                     stall_o
);
    import exe_pkg::*;

    logic [1:0]              stage_q;   // 0 idle, 1 operands held, 2 product ready
    logic                    sign1;
    logic                    sign2;
    logic signed [WIDTH:0]   op_a_q;
    logic signed [WIDTH:0]   op_b_q;
    logic [2*WIDTH-1:0]      prod_d;
    logic [2*WIDTH-1:0]      prod_q;

    assign sign1 = (op_i == OP_MULH) || (op_i == OP_MULHSU);
    assign sign2 = (op_i == OP_MULH);

    // Both operands carry one extra sign bit, so one signed multiply covers all variants
    assign prod_d = (2*WIDTH)'(op_a_q) * (2*WIDTH)'(op_b_q);

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            stage_q <= 2'd0;
        end else begin
            case (stage_q)
                2'd0:    stage_q <= request_i ? 2'd1 : 2'd0;
                2'd1:    stage_q <= 2'd2;
                default: stage_q <= 2'd0;  // Result cycle, back to idle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_q == 2'd0 && request_i) begin
            op_a_q <= {sign1 & src1_i[WIDTH-1], src1_i};
            op_b_q <= {sign2 & src2_i[WIDTH-1], src2_i};
        end
        if (stage_q == 2'd1) begin
            prod_q <= prod_d;
        end
    end

    assign stall_o  = request_i && (stage_q != 2'd2);
    assign result_o = (op_i == OP_MUL) ? prod_q[WIDTH-1:0] : prod_q[2*WIDTH-1:WIDTH];

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_exe_stage -f exe_stage.f \
    && ./obj_dir/Vtb_exe_stage \
    || exit 1

// ==== tb_exe_stage.sv ====
// Random execute-stage test from a fixed seed; inputs held during stalls, kill only hits divides
module tb_exe_stage;
    import exe_pkg::*;

    localparam int          NUM_INSTR = 3000;
    localparam int          PERIOD    = 100;
    localparam int          SETTLE    = 10;  // Sample point after the falling edge
    localparam logic [31:0] SEED      = 32'h56e4;
    localparam longint      WATCHDOG  = longint'(NUM_INSTR) * (XLEN + 4) * PERIOD + 20 * PERIOD;

    logic                clk_i, rst_i, kill_i, valid_i, use_pc_i, use_imm_i;
    logic [UNIT_W-1:0]   unit_i;
    logic [OP_W-1:0]     op_i;
    logic [XLEN-1:0]     pc_i, imm_i, rs1_data_i, rs2_data_i, bpred_target_i, wb_data_i;
    logic [REG_W-1:0]    rs1_i, rs2_i, rd_i, wb_rd_i;
    logic                bpred_taken_i, wb_valid_i, csr_interrupt_i;
    logic [CAUSE_W-1:0]  csr_interrupt_cause_i;
    logic                valid_o, stall_o, ex_valid_o, branch_taken_o, correct_pred_o;
    logic [REG_W-1:0]    rd_o;
    logic [XLEN-1:0]     result_o, ex_origin_o, branch_target_o;
    logic [CAUSE_W-1:0]  ex_cause_o;
    logic                pmu_is_branch_o, pmu_branch_taken_o, pmu_miss_prediction_o;
    logic                pmu_stall_mul_o, pmu_stall_div_o;

    // Model outputs for the instruction on the inputs
    logic [XLEN-1:0]     exp_result, exp_target, exp_origin;
    logic [CAUSE_W-1:0]  exp_cause;
    logic                exp_taken, exp_ex, exp_pred_ok;

    exe_stage dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG);
        abort_run("timeout, the instruction stream did not finish in time");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation aborted");
    endtask

    task automatic check(input string name, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("error at %0t: %s expected %h actual %h",
                                $time, name, expected, actual));
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [XLEN-1:0] forward(input logic [REG_W-1:0] idx,
                                                input logic [XLEN-1:0] data);
        return (wb_valid_i && idx != '0 && idx == wb_rd_i) ? wb_data_i : data;
    endfunction

    function automatic logic [XLEN-1:0] alu_model(input logic [OP_W-1:0] op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_SLL:  return a << b[4:0];
            OP_SLT:  return XLEN'($signed(a) < $signed(b));
            OP_SLTU: return XLEN'(a < b);
            OP_XOR:  return a ^ b;
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return $signed(a) >>> b[4:0];
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_LUI:  return b;
            default: return '0;
        endcase
    endfunction

    // RISC-V rules for zero divisor and signed overflow
    function automatic logic [XLEN-1:0] div_model(input logic [OP_W-1:0] op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic                   overflow;

        sa       = a;
        sb       = b;
        overflow = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
        if (b == '0)
            return (op == OP_DIV || op == OP_DIVU) ? '1 : a;
        if (overflow && (op == OP_DIV || op == OP_REM))
            return (op == OP_DIV) ? a : '0;
        case (op)
            OP_DIV:  return sa / sb;
            OP_REM:  return sa % sb;
            OP_DIVU: return a / b;
            default: return a % b;
        endcase
    endfunction

    task automatic predict();
        logic [XLEN-1:0]   s1, s2, a, b;
        logic [2*XLEN-1:0] x1, x2, prod;

        s1   = forward(rs1_i, rs1_data_i);
        s2   = forward(rs2_i, rs2_data_i);
        a    = use_pc_i ? pc_i : s1;
        b    = use_imm_i ? imm_i : s2;
        x1   = (op_i == OP_MULHU) ? {{XLEN{1'b0}}, s1} : {{XLEN{s1[XLEN-1]}}, s1};
        x2   = (op_i == OP_MULH) ? {{XLEN{s2[XLEN-1]}}, s2} : {{XLEN{1'b0}}, s2};
        prod = x1 * x2;
        exp_taken  = 1'b0;
        exp_target = (op_i == OP_JALR) ? ((s1 + imm_i) & ~32'd1) : pc_i + imm_i;
        case (unit_i)
            UNIT_ALU:    exp_result = alu_model(op_i, a, b);
            UNIT_MUL:    exp_result = (op_i == OP_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
            UNIT_DIV:    exp_result = div_model(op_i, s1, b);
            UNIT_SYSTEM: exp_result = s1;
            UNIT_BRANCH: begin
                case (op_i)
                    OP_BEQ:  exp_taken = s1 == s2;
                    OP_BNE:  exp_taken = s1 != s2;
                    OP_BLT:  exp_taken = $signed(s1) < $signed(s2);
                    OP_BGE:  exp_taken = $signed(s1) >= $signed(s2);
                    OP_BLTU: exp_taken = s1 < s2;
                    OP_BGEU: exp_taken = s1 >= s2;
                    default: exp_taken = 1'b1;  // JAL, JALR
                endcase
                exp_result = pc_i + 32'd4;
            end
            default:     exp_result = '0;
        endcase
        exp_taken   = exp_taken && valid_i;
        exp_pred_ok = !(valid_i && unit_i == UNIT_BRANCH) ||
                      (exp_taken == bpred_taken_i && (!exp_taken || exp_target == bpred_target_i));
        exp_ex      = valid_i && (csr_interrupt_i || (exp_taken && exp_target[1:0] != 2'b00));
        exp_cause   = csr_interrupt_i ? csr_interrupt_cause_i : CAUSE_INSTR_MISALIGNED;
        exp_origin  = csr_interrupt_i ? '0 : exp_target;
    endtask

    // ----------------------------------------
    // Stimulus and response
    // ----------------------------------------
    task automatic clear_inputs();
        {kill_i, valid_i, use_pc_i, use_imm_i, bpred_taken_i, wb_valid_i} = '0;
        {unit_i, op_i, rs1_i, rs2_i, rd_i, wb_rd_i} = '0;
        {pc_i, imm_i, rs1_data_i, rs2_data_i, bpred_target_i, wb_data_i} = '0;
        csr_interrupt_i       = 1'b0;
        csr_interrupt_cause_i = '0;
    endtask

    task automatic drive_random(input bit simple_only);
        int unsigned pick;

        pick    = $urandom_range(0, 99);
        valid_i = $urandom_range(0, 19) != 0;
        if (pick < 40 || (simple_only && pick >= 72)) begin
            unit_i = UNIT_ALU;
            op_i   = OP_ADD + OP_W'($urandom_range(0, 10));
        end else if (pick < 45) begin
            unit_i = UNIT_SYSTEM;
            op_i   = OP_ADD;
        end else if (pick < 47) begin
            unit_i = UNIT_W'($urandom_range(5, 7));  // Unused unit codes
            op_i   = OP_ADD;
        end else if (pick < 72) begin
            unit_i = UNIT_BRANCH;
            op_i   = OP_BEQ + OP_W'($urandom_range(0, 7));
        end else if (pick < 86) begin
            unit_i = UNIT_MUL;
            op_i   = OP_MUL + OP_W'($urandom_range(0, 3));
        end else begin
            unit_i = UNIT_DIV;
            op_i   = OP_DIV + OP_W'($urandom_range(0, 3));
        end
        pc_i  = $urandom & ~32'd3;
        imm_i = $urandom;
        if ($urandom_range(0, 7) != 0)
            imm_i[1:0] = 2'b00;  // Mostly aligned targets
        rs1_i      = ($urandom_range(0, 7) == 0) ? '0 : REG_W'($urandom);
        rs2_i      = ($urandom_range(0, 7) == 0) ? '0 : REG_W'($urandom);
        rs1_data_i = $urandom;
        rs2_data_i = ($urandom_range(0, 3) == 0) ? rs1_data_i : $urandom;
        rd_i       = REG_W'($urandom);
        use_pc_i   = $urandom_range(0, 1) == 1;
        use_imm_i  = $urandom_range(0, 1) == 1;
        wb_valid_i = $urandom_range(0, 1) == 1;
        wb_data_i  = $urandom;
        case ($urandom_range(0, 2))
            0:       wb_rd_i = rs1_i;
            1:       wb_rd_i = rs2_i;
            default: wb_rd_i = REG_W'($urandom);
        endcase
        bpred_taken_i         = $urandom_range(0, 1) == 1;
        bpred_target_i        = ($urandom_range(0, 1) == 1) ? pc_i + imm_i : $urandom;
        csr_interrupt_i       = $urandom_range(0, 15) == 0;
        csr_interrupt_cause_i = CAUSE_W'($urandom);
        // Directed divide by zero and most negative over -1
        if (unit_i == UNIT_DIV && $urandom_range(0, 3) == 0) begin
            wb_valid_i = 1'b0;
            use_imm_i  = 1'b1;
            imm_i      = ($urandom_range(0, 1) == 1) ? '0 : '1;
            rs1_data_i = ($urandom_range(0, 1) == 1) ? 32'h8000_0000 : $urandom;
        end
    endtask

    task automatic compare_outputs();
        check("valid_o", XLEN'(valid_i), XLEN'(valid_o));
        check("rd_o", XLEN'(rd_i), XLEN'(rd_o));
        check("pmu_stall_mul_o", 0, XLEN'(pmu_stall_mul_o));
        check("pmu_stall_div_o", 0, XLEN'(pmu_stall_div_o));
        check("ex_valid_o", XLEN'(exp_ex), XLEN'(ex_valid_o));
        check("branch_taken_o", XLEN'(exp_taken), XLEN'(branch_taken_o));
        check("correct_pred_o", XLEN'(exp_pred_ok), XLEN'(correct_pred_o));
        check("pmu_is_branch_o", XLEN'(valid_i && unit_i == UNIT_BRANCH), XLEN'(pmu_is_branch_o));
        check("pmu_branch_taken_o", XLEN'(exp_taken), XLEN'(pmu_branch_taken_o));
        check("pmu_miss_prediction_o", XLEN'(!exp_pred_ok), XLEN'(pmu_miss_prediction_o));
        if (valid_i)
            check("result_o", exp_result, result_o);
        if (exp_taken)
            check("branch_target_o", exp_target, branch_target_o);
        if (exp_ex) begin
            check("ex_cause_o", XLEN'(exp_cause), XLEN'(ex_cause_o));
            check("ex_origin_o", exp_origin, ex_origin_o);
        end
    endtask

    task automatic kill_divide();
        int unsigned busy_cycles;

        busy_cycles = $urandom_range(1, XLEN - 1);
        repeat (busy_cycles) begin
            #SETTLE;
            check("stall_o", 1, XLEN'(stall_o));
            @(negedge clk_i);
        end
        kill_i = 1'b1;  // Divide aborted at the next rising edge
    endtask

    initial begin
        int unsigned stalls;
        bit          after_kill;

        void'($urandom(SEED));
        clear_inputs();
        rst_i      = 1'b1;
        after_kill = 1'b0;
        repeat (16) @(negedge clk_i);
        rst_i = 1'b0;

        for (int n = 0; n < NUM_INSTR; n++) begin
            @(negedge clk_i);
            kill_i = 1'b0;
            drive_random(after_kill);
            predict();
            if (!after_kill && valid_i && unit_i == UNIT_DIV && $urandom_range(0, 24) == 0) begin
                kill_divide();
                after_kill = 1'b1;  // Next one must not stall
            end else begin
                after_kill = 1'b0;
                stalls     = 0;
                #SETTLE;
                while (stall_o) begin
                    check("pmu_stall_mul_o", XLEN'(unit_i == UNIT_MUL), XLEN'(pmu_stall_mul_o));
                    check("pmu_stall_div_o", XLEN'(unit_i == UNIT_DIV), XLEN'(pmu_stall_div_o));
                    stalls++;
                    if (stalls > XLEN + 4)
                        abort_run("stall_o stayed high far beyond the divider latency");
                    @(negedge clk_i);
                    #SETTLE;
                end
                if (valid_i && unit_i == UNIT_MUL)
                    check("multiplier stall cycles", 2, stalls);
                else if (!(valid_i && unit_i == UNIT_DIV))
                    check("stall cycles", 0, stalls);
                compare_outputs();
            end
        end
        $display("TEST PASS");
        $finish;
    end

endmodule
